//--- rtl/vmask_pkg.sv
package vmask_pkg;

  // ========================================
  // Lane geometry
  // ========================================
  localparam int VMASK_W = 32;               // Mask bits per lane

  // ========================================
  // Opcodes and internal classes
  // ========================================
  typedef enum logic [3:0] {
    VMAND  = 4'd0,  VMNAND = 4'd1,  VMANDN = 4'd2,  VMOR   = 4'd3,
    VMNOR  = 4'd4,  VMORN  = 4'd5,  VMXOR  = 4'd6,  VMXNOR = 4'd7,
    VCPOP  = 4'd8,  VFIRST = 4'd9,  VMSBF  = 4'd10, VMSIF  = 4'd11,
    VMSOF  = 4'd12, VIOTA  = 4'd13, VID    = 4'd14
  } vmask_op_e;

  // Inverted logicals fold into the three base classes
  typedef enum logic [3:0] {
    MT_AND, MT_OR, MT_XOR, MT_POPC, MT_FIRST,
    MT_SBF, MT_SIF, MT_SOF, MT_IOTA, MT_ID
  } vmask_type_e;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    vmask_op_e                    op;        // Instruction opcode
    logic [VMASK_W-1:0]           vs1;       // Mask source 1
    logic [VMASK_W-1:0]           vs2;       // Mask source 2
    logic [VMASK_W-1:0]           vmask;     // v0 enables
    logic [$clog2(VMASK_W)-1:0]   elem_idx;  // Element index for iota / id
  } vmask_req_t;

  typedef struct packed {
    vmask_type_e                  mask_type; // Operation class
    logic                         in_inv;    // Invert vs1 before the logical
    logic                         out_inv;   // Invert the logical result
    logic [VMASK_W-1:0]           vs1;
    logic [VMASK_W-1:0]           vs2;
    logic [VMASK_W-1:0]           vmask;
    logic [$clog2(VMASK_W)-1:0]   elem_idx;
  } vmask_dec_t;

  typedef struct packed {
    logic [VMASK_W-1:0]           wdata;     // Write value
    logic                         any_set;   // Some active bit was set
  } vmask_resp_t;

endpackage

//--- rtl/mask_operand_stage.sv
`timescale 1ns/1ps

module mask_operand_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  in_valid,
  input  vmask_pkg::vmask_req_t in_req,
  output logic                  dec_valid,
  output vmask_pkg::vmask_dec_t dec
);

  import vmask_pkg::*;

  vmask_dec_t dec_d;                          // Decoded request, before the register

  // ========================================
  // Opcode decode
  // ========================================
  always_comb begin
    dec_d          = '0;
    dec_d.vs1      = in_req.vs1;              // Operands pass straight through
    dec_d.vs2      = in_req.vs2;
    dec_d.vmask    = in_req.vmask;
    dec_d.elem_idx = in_req.elem_idx;
    case (in_req.op)
      VMAND  : dec_d.mask_type = MT_AND;
      VMNAND : begin
        dec_d.mask_type = MT_AND;
        dec_d.out_inv   = 1'b1;               // ~(vs2 & vs1)
      end
      VMANDN : begin
        dec_d.mask_type = MT_AND;
        dec_d.in_inv    = 1'b1;               // vs2 & ~vs1
      end
      VMOR   : dec_d.mask_type = MT_OR;
      VMNOR  : begin
        dec_d.mask_type = MT_OR;
        dec_d.out_inv   = 1'b1;
      end
      VMORN  : begin
        dec_d.mask_type = MT_OR;
        dec_d.in_inv    = 1'b1;
      end
      VMXOR  : dec_d.mask_type = MT_XOR;
      VMXNOR : begin
        dec_d.mask_type = MT_XOR;
        dec_d.out_inv   = 1'b1;
      end
      VCPOP  : dec_d.mask_type = MT_POPC;
      VFIRST : dec_d.mask_type = MT_FIRST;
      VMSBF  : dec_d.mask_type = MT_SBF;
      VMSIF  : dec_d.mask_type = MT_SIF;
      VMSOF  : dec_d.mask_type = MT_SOF;
      VIOTA  : dec_d.mask_type = MT_IOTA;
      VID    : dec_d.mask_type = MT_ID;
      // Unused opcode lands outside every class, so the unit writes zero
      default: dec_d.mask_type = vmask_type_e'(4'hf);
    endcase
  end

  // ========================================
  // Input register
  // ========================================
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      dec_valid <= 1'b0;
      dec       <= '0;
    end else begin
      dec_valid <= in_valid;                  // One-cycle strobe follows through
      if (in_valid) dec <= dec_d;             // Payload only moves with a request
    end
  end

endmodule

//--- rtl/first_set_encoder.sv
`timescale 1ns/1ps

module first_set_encoder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]         bits,
  output logic [$clog2(WIDTH)-1:0] index,
  output logic                     found
);

  localparam int IDX_W = $clog2(WIDTH);

  // ========================================
  // Lowest set bit wins
  // ========================================
  // Scan from the top down so later hits
  // overwrite earlier ones and the LSB side
  // has priority
  always_comb begin
    index = '0;                               // Zero when nothing is set
    found = 1'b0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      if (bits[i]) begin
        index = IDX_W'(i);
        found = 1'b1;
      end
    end
  end

endmodule

//--- rtl/popcount_tree.sv
`timescale 1ns/1ps

module popcount_tree #(
  parameter int WIDTH = 32                    // Multiple of 8
) (
  input  logic [WIDTH-1:0]       bits,
  output logic [$clog2(WIDTH):0] count
);

  localparam int NGRP  = WIDTH / 8;           // Number of byte groups
  localparam int CNT_W = $clog2(WIDTH) + 1;

  logic [3:0] grp_cnt [NGRP];                 // 0..8 per group

  // ========================================
  // Per-byte adder tree
  // ========================================
  for (genvar g = 0; g < NGRP; g++) begin : g_grp
    logic [1:0] pair_sum [4];                 // Level 1, bit pairs
    logic [2:0] quad_sum [2];                 // Level 2, nibbles
    for (genvar k = 0; k < 4; k++) begin : g_pair
      assign pair_sum[k] = {1'b0, bits[g*8 + 2*k]} + {1'b0, bits[g*8 + 2*k + 1]};
    end
    assign quad_sum[0] = {1'b0, pair_sum[0]} + {1'b0, pair_sum[1]};
    assign quad_sum[1] = {1'b0, pair_sum[2]} + {1'b0, pair_sum[3]};
    assign grp_cnt[g]  = {1'b0, quad_sum[0]} + {1'b0, quad_sum[1]};
  end

  // Final sum across the groups
  always_comb begin
    count = '0;
    for (int g = 0; g < NGRP; g++) begin
      count = count + CNT_W'(grp_cnt[g]);
    end
  end

endmodule

//--- rtl/mask_unit.sv
`timescale 1ns/1ps

module mask_unit #(
  parameter int WIDTH = vmask_pkg::VMASK_W
) (
  input  vmask_pkg::vmask_dec_t  dec,
  output vmask_pkg::vmask_resp_t resp
);

  import vmask_pkg::*;

  localparam int IDX_W = $clog2(WIDTH);
  localparam int CNT_W = IDX_W + 1;

  logic [WIDTH-1:0] active;                   // vs2 under the v0 enables
  logic [WIDTH-1:0] src1;                     // vs1 after optional inversion
  logic [WIDTH-1:0] logic_raw;
  logic [WIDTH-1:0] logic_res;
  logic [WIDTH-1:0] below_mask;               // Ones under elem_idx
  logic [WIDTH-1:0] sbf_bits;
  logic [WIDTH-1:0] sif_bits;
  logic [WIDTH-1:0] sof_bits;
  logic [IDX_W-1:0] first_idx;
  logic             first_found;
  logic [CNT_W-1:0] pop_cnt;
  logic [CNT_W-1:0] iota_cnt;

  // ========================================
  // Operand forming
  // ========================================
  assign active     = dec.vs2 & dec.vmask;
  assign src1       = dec.in_inv ? ~dec.vs1 : dec.vs1;
  assign below_mask = (WIDTH'(1) << dec.elem_idx) - WIDTH'(1);

  // Mask logicals ignore v0
  always_comb begin
    case (dec.mask_type)
      MT_OR   : logic_raw = dec.vs2 | src1;
      MT_XOR  : logic_raw = dec.vs2 ^ src1;
      default : logic_raw = dec.vs2 & src1;
    endcase
  end
  assign logic_res = dec.out_inv ? ~logic_raw : logic_raw;

  // ========================================
  // Encoder and counters
  // ========================================
  first_set_encoder #(.WIDTH(WIDTH)) enc0 (
    .bits  (active),
    .index (first_idx),
    .found (first_found)                      // Low when no active bit
  );

  popcount_tree #(.WIDTH(WIDTH)) pop_all (
    .bits  (active),
    .count (pop_cnt)
  );

  // Iota for this element only
  popcount_tree #(.WIDTH(WIDTH)) pop_below (
    .bits  (active & below_mask),
    .count (iota_cnt)
  );

  // First-set patterns
  assign sof_bits = first_found ? (WIDTH'(1) << first_idx) : '0;
  assign sbf_bits = first_found ? (sof_bits - WIDTH'(1)) : '1;  // All ones when none found
  assign sif_bits = sbf_bits | sof_bits;                         // Stays all ones when none found

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    case (dec.mask_type)
      MT_AND, MT_OR, MT_XOR : resp.wdata = logic_res;
      MT_POPC  : resp.wdata = WIDTH'(pop_cnt);
      MT_FIRST : resp.wdata = first_found ? WIDTH'(first_idx) : '1;  // -1 when empty
      MT_SBF   : resp.wdata = sbf_bits;
      MT_SIF   : resp.wdata = sif_bits;
      MT_SOF   : resp.wdata = sof_bits;
      MT_IOTA  : resp.wdata = WIDTH'(iota_cnt);
      MT_ID    : resp.wdata = WIDTH'(dec.elem_idx);
      default  : resp.wdata = '0;
    endcase
    resp.any_set = first_found;               // Same flag for every class
  end

endmodule

//--- rtl/mask_writeback.sv
`timescale 1ns/1ps

module mask_writeback (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   dec_valid,
  input  vmask_pkg::vmask_resp_t resp,
  output logic                   out_valid,
  output vmask_pkg::vmask_resp_t out_resp
);

  // ========================================
  // Output register
  // ========================================
  // The pulse is one cycle wide, the data
  // stays put until the next result lands

  // Valid pulse
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= dec_valid;
    end
  end

  // Response data
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_resp <= '0;                         // Clean zero after reset
    end else if (dec_valid) begin
      out_resp <= resp;                       // Capture only with a result
    end
  end

endmodule

//--- rtl/vmask_top.sv
`timescale 1ns/1ps

module vmask_top #(
  parameter int WIDTH = vmask_pkg::VMASK_W
) (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   in_valid,
  input  vmask_pkg::vmask_req_t  in_req,
  output logic                   out_valid,
  output vmask_pkg::vmask_resp_t out_resp
);

  import vmask_pkg::*;

  logic        dec_valid;                     // Stage 1 valid
  vmask_dec_t  dec;                           // Stage 1 payload
  vmask_resp_t resp;                          // Combinational result

  // ========================================
  // Three-stage pipe, 2 cycles in to out
  // ========================================
  mask_operand_stage stage0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  mask_unit #(.WIDTH(WIDTH)) unit0 (
    .dec  (dec),
    .resp (resp)
  );

  mask_writeback wb0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .dec_valid (dec_valid),
    .resp      (resp),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

endmodule

//--- bench/vmask_props.sv
`timescale 1ns/1ps

module vmask_props (
  input logic                   CLK,
  input logic                   nRST,
  input logic                   in_valid,
  input logic                   out_valid,
  input vmask_pkg::vmask_resp_t out_resp
);

  // ========================================
  // Pipeline timing and reset
  // ========================================
  a_latency : assert property (@(posedge CLK) disable iff (!nRST)
    out_valid == $past(in_valid, 2))          // Fixed two-cycle pipe
    else $error("out_valid does not follow in_valid by two cycles");

  a_reset_quiet : assert property (@(posedge CLK) !nRST |-> !out_valid)
    else $error("out_valid high during reset");

  // Data must be clean whenever it is offered
  a_resp_known : assert property (@(posedge CLK) disable iff (!nRST)
    out_valid |-> !$isunknown(out_resp))
    else $error("out_resp has unknown bits while out_valid is high");

endmodule

bind vmask_top vmask_props props0 (
  .CLK       (CLK),
  .nRST      (nRST),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .out_resp  (out_resp)
);

//--- include/vmask_model.svh
`ifndef VMASK_MODEL_SVH
`define VMASK_MODEL_SVH

// ========================================
// Bit-by-bit reference for one request
// ========================================
function automatic vmask_pkg::vmask_resp_t vmask_model(input vmask_pkg::vmask_req_t req);
  logic [vmask_pkg::VMASK_W-1:0] active;
  logic [vmask_pkg::VMASK_W-1:0] wdata;
  int                            first;      // -1 when no active bit
  int                            cnt;
  vmask_pkg::vmask_resp_t        resp;

  active = req.vs2 & req.vmask;
  first  = -1;
  cnt    = 0;
  for (int i = vmask_pkg::VMASK_W - 1; i >= 0; i--) begin
    if (active[i]) first = i;                // Lowest index survives
  end

  case (req.op)
    vmask_pkg::VMAND  : wdata = req.vs2 & req.vs1;
    vmask_pkg::VMNAND : wdata = ~(req.vs2 & req.vs1);
    vmask_pkg::VMANDN : wdata = req.vs2 & ~req.vs1;
    vmask_pkg::VMOR   : wdata = req.vs2 | req.vs1;
    vmask_pkg::VMNOR  : wdata = ~(req.vs2 | req.vs1);
    vmask_pkg::VMORN  : wdata = req.vs2 | ~req.vs1;
    vmask_pkg::VMXOR  : wdata = req.vs2 ^ req.vs1;
    vmask_pkg::VMXNOR : wdata = ~(req.vs2 ^ req.vs1);
    vmask_pkg::VCPOP  : wdata = $countones(active);
    vmask_pkg::VFIRST : wdata = (first < 0) ? '1 : first;
    vmask_pkg::VMSBF, vmask_pkg::VMSIF, vmask_pkg::VMSOF : begin
      for (int i = 0; i < vmask_pkg::VMASK_W; i++) begin
        if (req.op == vmask_pkg::VMSBF) wdata[i] = (first < 0) || (i < first);
        else if (req.op == vmask_pkg::VMSIF) wdata[i] = (first < 0) || (i <= first);
        else wdata[i] = (i == first);          // Zero when no first bit
      end
    end
    vmask_pkg::VIOTA  : begin
      for (int i = 0; i < int'(req.elem_idx); i++) begin
        if (active[i]) cnt++;
      end
      wdata = cnt;
    end
    vmask_pkg::VID    : wdata = req.elem_idx;
    default           : wdata = '0;
  endcase

  resp.wdata   = wdata;
  resp.any_set = |active;
  return resp;
endfunction

`endif

//--- bench/vmask_tb.sv
`timescale 1ns/1ps

module vmask_tb;

  import vmask_pkg::*;

  `include "vmask_model.svh"

  // ========================================
  // Run length and limits
  // ========================================
  localparam int SEED        = 32'hce41;
  localparam int N_DIRECTED  = 99;            // 8x4 logicals, 5x7 scan ops, 2x16 iota/id
  localparam int N_BURST     = 200;           // Back-to-back phase
  localparam int N_GAPPED    = 100;           // Requests with idle gaps
  localparam int MAX_GAP     = 3;
  localparam int TOTAL_REQ   = N_DIRECTED + N_BURST + N_GAPPED;
  localparam int TIMEOUT_CYC = TOTAL_REQ * (MAX_GAP + 1) + 20;

  logic        CLK;
  logic        nRST;
  logic        in_valid;
  vmask_req_t  in_req;
  logic        out_valid;
  vmask_resp_t out_resp;

  vmask_resp_t exp_q[$];                      // Expected responses, oldest first
  int          issue_q[$];                    // Cycle each request was driven
  int          cycle = 0;
  vmask_resp_t last_resp = '0;                // Value the output register should hold

  vmask_top #(.WIDTH(VMASK_W)) dut0 (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;                    // 8 ns period
  end

  // Cycle count and watchdog
  always @(posedge CLK) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYC) begin
      $display("Timeout: results still missing after %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  function automatic vmask_op_e rand_op();
    return vmask_op_e'(4'($urandom_range(14, 0)));
  endfunction

  function automatic vmask_req_t rand_req(input vmask_op_e op);
    vmask_req_t r;
    r.op       = op;
    r.vs1      = $urandom();
    r.vs2      = $urandom();
    r.vmask    = $urandom();
    r.elem_idx = 5'($urandom_range(31, 0));
    return r;
  endfunction

  // ========================================
  // Drive side, falling edge
  // ========================================
  task automatic send(input vmask_req_t req);
    @(negedge CLK);
    in_valid = 1'b1;
    in_req   = req;
    exp_q.push_back(vmask_model(req));
    issue_q.push_back(cycle);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge CLK);
      in_valid = 1'b0;
      in_req   = rand_req(VID);               // Junk payload must not reach the output
    end
  endtask

  // Random, no active bit, full mask, single active bit
  task automatic send_varied(input vmask_op_e op);
    vmask_req_t r;
    repeat (4) send(rand_req(op));
    r = rand_req(op);
    r.vmask = '0;
    send(r);
    r.vs2 = '1;
    r.vmask = '1;
    send(r);
    r.vs2 = 32'h1 << $urandom_range(31, 0);
    send(r);
  endtask

  // ========================================
  // Result side, compared against the model
  // ========================================
  always @(negedge CLK) begin : monitor
    vmask_resp_t exp_resp;
    int          lat;
    if (!nRST) begin
      check_equal(64'(out_valid), 64'd0, "out_valid during reset");
      check_equal(64'(out_resp), 64'd0, "out_resp during reset");
    end else if (out_valid) begin
      if (exp_q.size() == 0) begin
        $display("A result appeared at %0t ns with no request outstanding", $time);
        $display("Regression failed");
        $fatal(1, "Unexpected result");
      end else begin
        exp_resp = exp_q.pop_front();
        lat      = cycle - issue_q.pop_front();
        check_equal(64'(out_resp), 64'(exp_resp), "response");
        check_equal(64'(lat), 64'd2, "latency in cycles");
        last_resp = exp_resp;
      end
    end else begin
      // Between pulses the last result stays readable
      check_equal(64'(out_resp), 64'(last_resp), "held response between pulses");
    end
  end

  initial begin
    void'($urandom(SEED));
    nRST     = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    idle(3);                                  // Quiet output after reset
    for (int op = 0; op < 8; op++) begin
      repeat (4) send(rand_req(vmask_op_e'(4'(op))));
    end
    idle(1);
    send_varied(VCPOP);
    send_varied(VFIRST);
    send_varied(VMSBF);
    send_varied(VMSIF);
    send_varied(VMSOF);
    idle(1);
    repeat (16) send(rand_req(VIOTA));
    repeat (16) send(rand_req(VID));
    idle(2);
    repeat (N_BURST) send(rand_req(rand_op()));  // Full throughput
    repeat (N_GAPPED) begin
      send(rand_req(rand_op()));
      idle($urandom_range(MAX_GAP, 0));
    end
    idle(1);
    while (exp_q.size() != 0) @(negedge CLK);
    idle(4);                                  // No stray pulses after the drain
    $display("Regression passed");
    $finish;
  end

endmodule

//--- project.f
+incdir+include
rtl/vmask_pkg.sv
rtl/mask_operand_stage.sv
rtl/first_set_encoder.sv
rtl/popcount_tree.sv
rtl/mask_unit.sv
rtl/mask_writeback.sv
rtl/vmask_top.sv
bench/vmask_props.sv
bench/vmask_tb.sv

//--- Makefile
# Verilator build and run for the mask-operation block
VERILATOR ?= verilator
TOP       ?= vmask_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST)) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulator is the verdict
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
